//--- hw/mmu_pkg.sv
package mmu_pkg;

    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = $clog2(tlb_num);

    localparam int asid_w = 10;
    localparam int vppn_w = 19;
    localparam int ppn_w  = 20;
    localparam int ps_w   = 6;

    localparam logic [ps_w-1:0] page_ps_4k = 6'd12;
    localparam logic [ps_w-1:0] page_ps_2m = 6'd21;

    // vppn bit where the 2 MB compare starts, the bit below picks the odd page
    localparam int vppn_2m_lsb = int'(page_ps_2m) - int'(page_ps_4k);

    typedef enum logic [5:0] {
        fault_none = 6'd0,
        fault_pil  = 6'd1,
        fault_pis  = 6'd2,
        fault_pif  = 6'd3,
        fault_pme  = 6'd4,
        fault_ppi  = 6'd7,
        fault_tlbr = 6'd63
    } xlat_fault_e;

    typedef enum logic [1:0] {
        acc_fetch = 2'd0,
        acc_load  = 2'd1,
        acc_store = 2'd2
    } access_e;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [vppn_w-1:0] vppn;
        logic [ps_w-1:0]   ps;
        logic              g;
        logic [asid_w-1:0] asid;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [2:0] vseg;
        logic [2:0] pseg;
        logic [1:0] mat;
    } dmw_t;

    typedef struct packed {
        logic              pg;
        logic [1:0]        plv;
        logic [asid_w-1:0] asid;
        dmw_t              dmw0;
        dmw_t              dmw1;
    } xlat_cfg_t;

    // same address word, seen by the windows or by the TLB
    typedef union packed {
        struct packed {
            logic [2:0]  vseg;
            logic [28:0] rest;
        } win;
        struct packed {
            logic [vppn_w-1:0] vppn;
            logic              odd;
            logic [11:0]       offset;
        } page;
    } vaddr_u;

    typedef struct packed {
        vaddr_u  va;
        access_e kind;
    } xlat_req_t;

    typedef struct packed {
        logic [31:0] pa;
        logic [1:0]  mat;
        xlat_fault_e fault;
    } xlat_rsp_t;

    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [ps_w-1:0]      ps;
        tlb_page_t            page;
    } tlb_hit_t;

    typedef struct packed {
        logic [2:0]        op;
        logic [asid_w-1:0] asid;
        vaddr_u            va;
    } invtlb_t;

    // a 2 MB entry only compares va[31:22]
    function automatic logic vppn_match(tlb_entry_t ent, vaddr_u va);
        if (ent.ps == page_ps_2m) begin
            return ent.vppn[vppn_w-1:vppn_2m_lsb] == va.page.vppn[vppn_w-1:vppn_2m_lsb];
        end
        return ent.vppn == va.page.vppn;
    endfunction

endpackage

//--- hw/tlb_array.sv
`timescale 1ns/1ps

module tlb_array (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // index-directed write
    input  logic                                          wr_en,
    input  logic [mmu_pkg::tlb_idx_w-1:0]                 wr_index,
    input  mmu_pkg::tlb_entry_t                           wr_entry,
    // registered read
    input  logic                                          rd_en,
    input  logic [mmu_pkg::tlb_idx_w-1:0]                 rd_index,
    output logic                                          rd_valid,
    output mmu_pkg::tlb_entry_t                           rd_entry,
    // invalidate
    input  logic                                          inv_en,
    input  mmu_pkg::invtlb_t                              inv,
    output mmu_pkg::tlb_entry_t [mmu_pkg::tlb_num-1:0]    entries
);
    import mmu_pkg::*;

    tlb_entry_t         mem [tlb_num];
    logic [tlb_num-1:0] ent_e;
    logic [tlb_num-1:0] inv_hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // exist bits live apart from the payload so reset can clear them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_e <= '0;
        end else begin
            for (int i = 0; i < tlb_num; i++) begin
                if (wr_en && wr_index == tlb_idx_w'(i)) begin
                    ent_e[i] <= wr_entry.e;
                end else if (inv_en && inv_hit[i]) begin
                    ent_e[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            entries[i]   = mem[i];
            entries[i].e = ent_e[i];
        end
    end

    // which entries an invalidate op removes
    always_comb begin
        logic asid_eq;
        logic va_eq;
        for (int i = 0; i < tlb_num; i++) begin
            asid_eq = entries[i].asid == inv.asid;
            va_eq   = vppn_match(entries[i], inv.va);
            case (inv.op)
                3'd0, 3'd1: inv_hit[i] = 1'b1;
                3'd2:       inv_hit[i] = entries[i].g;
                3'd3:       inv_hit[i] = !entries[i].g;
                3'd4:       inv_hit[i] = !entries[i].g && asid_eq;
                3'd5:       inv_hit[i] = !entries[i].g && asid_eq && va_eq;
                3'd6:       inv_hit[i] = (entries[i].g || asid_eq) && va_eq;
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= entries[rd_index];
        end
    end

endmodule

//--- hw/tlb_search.sv
`timescale 1ns/1ps

module tlb_search (
    input  mmu_pkg::vaddr_u                               va,
    input  logic [mmu_pkg::asid_w-1:0]                    asid,
    input  mmu_pkg::tlb_entry_t [mmu_pkg::tlb_num-1:0]    entries,
    output mmu_pkg::tlb_hit_t                             hit
);
    import mmu_pkg::*;

    logic [tlb_num-1:0] match;

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            match[i] = entries[i].e
                    && (entries[i].g || entries[i].asid == asid)
                    && vppn_match(entries[i], va);
        end
    end

    // lowest index wins if software left duplicates behind
    always_comb begin
        logic odd;
        hit = '0;
        odd = 1'b0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit.found = 1'b1;
                hit.index = tlb_idx_w'(i);
                hit.ps    = entries[i].ps;
                if (entries[i].ps == page_ps_2m) begin
                    // va bit 21
                    odd = va.page.vppn[vppn_2m_lsb - 1];
                end else begin
                    odd = va.page.odd;
                end
                hit.page = odd ? entries[i].page1 : entries[i].page0;
            end
        end
    end

endmodule

//--- hw/xlat_stage.sv
`timescale 1ns/1ps

module xlat_stage (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  mmu_pkg::xlat_cfg_t                            cfg,
    input  mmu_pkg::tlb_entry_t [mmu_pkg::tlb_num-1:0]    entries,
    // request side
    input  logic                                          req_valid,
    input  mmu_pkg::xlat_req_t                            req,
    output logic                                          req_allowin,
    // result side
    output logic                                          rsp_valid,
    output mmu_pkg::xlat_rsp_t                            rsp,
    input  logic                                          rsp_ready
);
    import mmu_pkg::*;

    tlb_hit_t    hit;
    xlat_rsp_t   rsp_next;
    logic [31:0] va_bits;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        accept;

    function automatic logic dmw_match(dmw_t w, logic [1:0] plv, logic [2:0] vseg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return plv_ok && w.vseg == vseg;
    endfunction

    tlb_search u_search (
        .va      (req.va),
        .asid    (cfg.asid),
        .entries (entries),
        .hit     (hit)
    );

    assign va_bits  = req.va;
    assign dmw0_hit = dmw_match(cfg.dmw0, cfg.plv, req.va.win.vseg);
    assign dmw1_hit = dmw_match(cfg.dmw1, cfg.plv, req.va.win.vseg);

    // faults return pa and mat as zero
    always_comb begin
        rsp_next.pa    = '0;
        rsp_next.mat   = 2'd0;
        rsp_next.fault = fault_none;
        if (!cfg.pg) begin
            rsp_next.pa  = va_bits;
            rsp_next.mat = 2'd1;
        end else if (dmw0_hit) begin
            rsp_next.pa  = {cfg.dmw0.pseg, req.va.win.rest};
            rsp_next.mat = cfg.dmw0.mat;
        end else if (dmw1_hit) begin
            rsp_next.pa  = {cfg.dmw1.pseg, req.va.win.rest};
            rsp_next.mat = cfg.dmw1.mat;
        end else if (!hit.found) begin
            rsp_next.fault = fault_tlbr;
        end else if (!hit.page.v) begin
            case (req.kind)
                acc_fetch: rsp_next.fault = fault_pif;
                acc_store: rsp_next.fault = fault_pis;
                default:   rsp_next.fault = fault_pil;
            endcase
        end else if (cfg.plv > hit.page.plv) begin
            rsp_next.fault = fault_ppi;
        end else if (req.kind == acc_store && !hit.page.d) begin
            rsp_next.fault = fault_pme;
        end else begin
            rsp_next.mat = hit.page.mat;
            if (hit.ps == page_ps_2m) begin
                rsp_next.pa = {hit.page.ppn[ppn_w-1:vppn_2m_lsb], va_bits[page_ps_2m-1:0]};
            end else begin
                rsp_next.pa = {hit.page.ppn, req.va.page.offset};
            end
        end
    end

    // result register, refills in the cycle it is drained
    assign req_allowin = !rsp_valid || rsp_ready;
    assign accept      = req_valid && req_allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_allowin) begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

endmodule

//--- hw/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mmu_pkg::xlat_cfg_t            cfg,
    // port 0, fetch
    input  logic                          req_valid_0,
    input  mmu_pkg::xlat_req_t            req_0,
    output logic                          req_allowin_0,
    output logic                          rsp_valid_0,
    output mmu_pkg::xlat_rsp_t            rsp_0,
    input  logic                          rsp_ready_0,
    // port 1, load and store
    input  logic                          req_valid_1,
    input  mmu_pkg::xlat_req_t            req_1,
    output logic                          req_allowin_1,
    output logic                          rsp_valid_1,
    output mmu_pkg::xlat_rsp_t            rsp_1,
    input  logic                          rsp_ready_1,
    // management
    input  logic                          wr_en,
    input  logic [mmu_pkg::tlb_idx_w-1:0] wr_index,
    input  mmu_pkg::tlb_entry_t           wr_entry,
    input  logic                          rd_en,
    input  logic [mmu_pkg::tlb_idx_w-1:0] rd_index,
    output logic                          rd_valid,
    output mmu_pkg::tlb_entry_t           rd_entry,
    input  logic                          inv_en,
    input  mmu_pkg::invtlb_t              inv
);
    import mmu_pkg::*;

    tlb_entry_t [tlb_num-1:0] entries;

    tlb_array tlb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry),
        .inv_en   (inv_en),
        .inv      (inv),
        .entries  (entries)
    );

    xlat_stage xlat0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .entries     (entries),
        .req_valid   (req_valid_0),
        .req         (req_0),
        .req_allowin (req_allowin_0),
        .rsp_valid   (rsp_valid_0),
        .rsp         (rsp_0),
        .rsp_ready   (rsp_ready_0)
    );

    xlat_stage xlat1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .entries     (entries),
        .req_valid   (req_valid_1),
        .req         (req_1),
        .req_allowin (req_allowin_1),
        .rsp_valid   (rsp_valid_1),
        .rsp         (rsp_1),
        .rsp_ready   (rsp_ready_1)
    );

endmodule

//--- bench/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    typedef enum int {op_cfg, op_wr, op_rd, op_inv, op_xl, op_burst} op_kind_e;

    typedef struct {
        op_kind_e   kind;
        int         port;
        int         index;
        xlat_cfg_t  cfg;
        tlb_entry_t ent;
        invtlb_t    inv;
        xlat_req_t  req;
        xlat_rsp_t  exp;
    } op_t;

    localparam int burst_len = 20;

    logic                 clk;
    logic                 rst_n;
    xlat_cfg_t            cfg;
    logic                 req_valid_0;
    xlat_req_t            req_0;
    logic                 req_allowin_0;
    logic                 rsp_valid_0;
    xlat_rsp_t            rsp_0;
    logic                 rsp_ready_0;
    logic                 req_valid_1;
    xlat_req_t            req_1;
    logic                 req_allowin_1;
    logic                 rsp_valid_1;
    xlat_rsp_t            rsp_1;
    logic                 rsp_ready_1;
    logic                 wr_en;
    logic [tlb_idx_w-1:0] wr_index;
    tlb_entry_t           wr_entry;
    logic                 rd_en;
    logic [tlb_idx_w-1:0] rd_index;
    logic                 rd_valid;
    tlb_entry_t           rd_entry;
    logic                 inv_en;
    invtlb_t              inv;

    op_t         tbl [80];
    int          n_ops = 0;
    int          cur_op = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    logic [31:0] lfsr = 32'had96;

    mmu_top dut0 (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            halt_failed();
        end
    end

    task automatic halt_failed();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        halt_failed();
    endtask

    task automatic check_rsp(string name, xlat_rsp_t got, xlat_rsp_t exp);
        if (got !== exp) begin
            $display("[FAIL] op %0d %s got %h expected %h", cur_op, name, got, exp);
            halt_failed();
        end
    endtask

    task automatic check_entry(string name, tlb_entry_t got, tlb_entry_t exp);
        if (got !== exp) begin
            $display("[FAIL] op %0d %s got %h expected %h", cur_op, name, got, exp);
            halt_failed();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] op %0d %s got %h expected %h", cur_op, name, got, exp);
            halt_failed();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic xlat_rsp_t ok_rsp(logic [31:0] pa, logic [1:0] mat);
        return '{pa, mat, fault_none};
    endfunction

    function automatic xlat_rsp_t fault_rsp(xlat_fault_e f);
        return '{32'h0, 2'd0, f};
    endfunction

    function automatic xlat_cfg_t mk_cfg(logic pg, logic [1:0] plv, logic [9:0] asid,
                                         dmw_t d0, dmw_t d1);
        return '{pg, plv, asid, d0, d1};
    endfunction

    function automatic tlb_page_t mk_page(logic [19:0] ppn, logic [1:0] plv, logic [1:0] mat,
                                          logic d, logic v);
        return '{ppn, plv, mat, d, v};
    endfunction

    function automatic tlb_entry_t mk_ent(logic [18:0] vppn, logic [5:0] ps, logic g,
                                          logic [9:0] asid, tlb_page_t p0, tlb_page_t p1);
        return '{1'b1, vppn, ps, g, asid, p0, p1};
    endfunction

    function automatic tlb_entry_t without_e(tlb_entry_t t);
        t.e = 1'b0;
        return t;
    endfunction

    // burst addresses carry port and sequence number so order errors show up
    function automatic logic [31:0] burst_va(int p, int i);
        return {4'h8 | 4'(p), 8'(i), 20'habc00};
    endfunction

    function automatic xlat_req_t burst_req(int p, int i);
        xlat_req_t r;
        r.va   = burst_va(p, i);
        r.kind = (p == 0) ? acc_fetch : acc_load;
        return r;
    endfunction

    task automatic add_cfg(xlat_cfg_t c);
        tbl[n_ops].kind = op_cfg;
        tbl[n_ops].cfg  = c;
        n_ops++;
    endtask

    task automatic add_ent_op(op_kind_e k, int idx, tlb_entry_t t);
        tbl[n_ops].kind  = k;
        tbl[n_ops].index = idx;
        tbl[n_ops].ent   = t;
        n_ops++;
    endtask

    task automatic add_inv(logic [2:0] op, logic [9:0] asid, logic [31:0] va);
        tbl[n_ops].kind     = op_inv;
        tbl[n_ops].inv.op   = op;
        tbl[n_ops].inv.asid = asid;
        tbl[n_ops].inv.va   = va;
        n_ops++;
    endtask

    task automatic add_xl(int port, logic [31:0] va, access_e k, xlat_rsp_t e);
        tbl[n_ops].kind     = op_xl;
        tbl[n_ops].port     = port;
        tbl[n_ops].req.va   = va;
        tbl[n_ops].req.kind = k;
        tbl[n_ops].exp      = e;
        n_ops++;
    endtask

    task automatic build_table();
        dmw_t       win0;
        dmw_t       win1;
        dmw_t       win1_p0;
        dmw_t       off;
        tlb_entry_t ent0;
        tlb_entry_t ent1;
        tlb_entry_t ent2;
        tlb_entry_t ent3;
        win0    = '{1'b1, 1'b0, 3'h5, 3'h0, 2'd1};
        win1    = '{1'b1, 1'b1, 3'h5, 3'h1, 2'd0};
        win1_p0 = '{1'b1, 1'b0, 3'h5, 3'h1, 2'd0};
        off     = '0;
        ent0 = mk_ent(19'h00010, page_ps_4k, 1'b0, 10'h005,
                      mk_page(20'h12345, 2'd0, 2'd1, 1'b1, 1'b1),
                      mk_page(20'h54321, 2'd3, 2'd2, 1'b0, 1'b1));
        // global 2 MB pair at va 0x00400000
        ent1 = mk_ent(19'h00200, page_ps_2m, 1'b1, 10'h003,
                      mk_page(20'h00a00, 2'd3, 2'd1, 1'b1, 1'b1),
                      mk_page(20'h01200, 2'd3, 2'd0, 1'b1, 1'b1));
        ent2 = mk_ent(19'h00020, page_ps_4k, 1'b0, 10'h007,
                      mk_page(20'h0f0f0, 2'd3, 2'd1, 1'b1, 1'b1),
                      mk_page(20'h0e0e0, 2'd3, 2'd1, 1'b1, 1'b1));
        ent3 = mk_ent(19'h00030, page_ps_4k, 1'b0, 10'h005,
                      mk_page(20'h0dead, 2'd0, 2'd1, 1'b1, 1'b0),
                      mk_page(20'h0abcd, 2'd0, 2'd1, 1'b0, 1'b1));

        // direct mode ignores the windows
        add_cfg(mk_cfg(1'b0, 2'd0, 10'h005, win0, win1));
        add_xl(0, 32'h1234_5678, acc_fetch, ok_rsp(32'h1234_5678, 2'd1));
        add_xl(1, 32'hfedc_ba98, acc_store, ok_rsp(32'hfedc_ba98, 2'd1));
        add_xl(1, 32'ha000_0004, acc_load, ok_rsp(32'ha000_0004, 2'd1));
        add_cfg(mk_cfg(1'b1, 2'd0, 10'h005, win0, win1));
        add_xl(1, 32'ha000_1234, acc_load, ok_rsp(32'h0000_1234, 2'd1));
        add_xl(0, 32'hbfff_fff0, acc_fetch, ok_rsp(32'h1fff_fff0, 2'd1));
        add_xl(1, 32'h0000_8000, acc_load, fault_rsp(fault_tlbr));
        add_cfg(mk_cfg(1'b1, 2'd3, 10'h005, win0, win1));
        add_xl(1, 32'ha000_1234, acc_store, ok_rsp(32'h2000_1234, 2'd0));
        add_cfg(mk_cfg(1'b1, 2'd3, 10'h005, win0, win1_p0));
        add_xl(0, 32'ha000_1234, acc_fetch, fault_rsp(fault_tlbr));

        add_cfg(mk_cfg(1'b1, 2'd0, 10'h005, off, off));
        add_ent_op(op_wr, 0, ent0);
        add_ent_op(op_wr, 1, ent1);
        add_ent_op(op_wr, 2, ent2);
        add_ent_op(op_wr, 3, ent3);
        add_xl(0, 32'h0002_0abc, acc_fetch, ok_rsp(32'h1234_5abc, 2'd1));
        add_xl(1, 32'h0002_1def, acc_load, ok_rsp(32'h5432_1def, 2'd2));
        add_xl(1, 32'h0002_1def, acc_store, fault_rsp(fault_pme));
        add_xl(0, 32'h0041_2345, acc_fetch, ok_rsp(32'h00a1_2345, 2'd1));
        add_xl(1, 32'h0065_4321, acc_load, ok_rsp(32'h0125_4321, 2'd0));
        add_xl(1, 32'h0004_0010, acc_load, fault_rsp(fault_tlbr));
        add_xl(0, 32'h0006_0100, acc_fetch, fault_rsp(fault_pif));
        add_xl(1, 32'h0006_0100, acc_load, fault_rsp(fault_pil));
        add_xl(1, 32'h0006_0100, acc_store, fault_rsp(fault_pis));
        add_xl(1, 32'h0006_1100, acc_store, fault_rsp(fault_pme));
        add_xl(1, 32'h0006_1100, acc_load, ok_rsp(32'h0abc_d100, 2'd1));
        add_cfg(mk_cfg(1'b1, 2'd3, 10'h005, off, off));
        add_xl(1, 32'h0006_1100, acc_load, fault_rsp(fault_ppi));
        add_xl(0, 32'h0002_0abc, acc_fetch, fault_rsp(fault_ppi));
        add_xl(1, 32'h0002_1def, acc_load, ok_rsp(32'h5432_1def, 2'd2));
        add_cfg(mk_cfg(1'b1, 2'd0, 10'h007, off, off));
        add_xl(1, 32'h0004_0010, acc_load, ok_rsp(32'h0f0f_0010, 2'd1));
        add_cfg(mk_cfg(1'b1, 2'd0, 10'h005, off, off));

        add_ent_op(op_rd, 0, ent0);
        add_ent_op(op_rd, 1, ent1);
        add_ent_op(op_rd, 3, ent3);
        add_inv(3'd5, 10'h005, 32'h0002_0000);
        add_xl(0, 32'h0002_0abc, acc_fetch, fault_rsp(fault_tlbr));
        add_xl(0, 32'h0041_2345, acc_fetch, ok_rsp(32'h00a1_2345, 2'd1));
        add_ent_op(op_rd, 0, without_e(ent0));
        add_inv(3'd2, 10'h000, 32'h0);
        add_xl(1, 32'h0041_2345, acc_load, fault_rsp(fault_tlbr));
        add_ent_op(op_wr, 1, ent1);
        // inside the 2 MB page but off its first 4 KB
        add_inv(3'd6, 10'h005, 32'h0050_0000);
        add_ent_op(op_rd, 1, without_e(ent1));
        add_inv(3'd4, 10'h007, 32'h0);
        add_ent_op(op_rd, 2, without_e(ent2));
        add_xl(1, 32'h0006_1100, acc_load, ok_rsp(32'h0abc_d100, 2'd1));
        add_ent_op(op_wr, 1, ent1);
        add_inv(3'd3, 10'h000, 32'h0);
        add_xl(1, 32'h0006_1100, acc_load, fault_rsp(fault_tlbr));
        add_ent_op(op_wr, 4, ent0);
        add_xl(0, 32'h0041_2345, acc_fetch, ok_rsp(32'h00a1_2345, 2'd1));
        add_inv(3'd0, 10'h000, 32'h0);
        add_ent_op(op_rd, 4, without_e(ent0));
        add_xl(1, 32'h0065_4321, acc_load, fault_rsp(fault_tlbr));
        add_ent_op(op_wr, 5, ent1);
        add_inv(3'd1, 10'h000, 32'h0);
        add_ent_op(op_rd, 5, without_e(ent1));

        add_cfg(mk_cfg(1'b0, 2'd0, 10'h005, off, off));
        tbl[n_ops].kind = op_burst;
        n_ops++;
    endtask

    task automatic do_translate(int port, xlat_req_t r, xlat_rsp_t e);
        int waited;
        waited = 0;
        if (port == 0) begin
            req_valid_0 = 1'b1;
            req_0       = r;
        end else begin
            req_valid_1 = 1'b1;
            req_1       = r;
        end
        while ((port == 0) ? !req_allowin_0 : !req_allowin_1) begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                report_error($sformatf("port %0d kept req_allowin low", port));
            end
        end
        @(negedge clk);
        req_valid_0 = 1'b0;
        req_valid_1 = 1'b0;
        if (!((port == 0) ? rsp_valid_0 : rsp_valid_1)) begin
            report_error($sformatf("port %0d gave no result one cycle after acceptance", port));
        end
        check_rsp($sformatf("rsp_%0d", port), (port == 0) ? rsp_0 : rsp_1, e);
    endtask

    // both ports stream back to back while rsp_ready toggles at random
    task automatic run_burst();
        int         sent [2];
        int         done [2];
        logic [1:0] vld;
        logic [1:0] rdy;
        logic [1:0] alw;
        sent = '{0, 0};
        done = '{0, 0};
        while (done[0] < burst_len || done[1] < burst_len) begin
            vld = {rsp_valid_1, rsp_valid_0};
            for (int p = 0; p < 2; p++) begin
                if (vld[p] != (sent[p] > done[p])) begin
                    report_error($sformatf("port %0d rsp_valid disagrees with results owed", p));
                end
                if (vld[p]) begin
                    check_rsp($sformatf("rsp_%0d", p), (p == 0) ? rsp_0 : rsp_1,
                              ok_rsp(burst_va(p, done[p]), 2'd1));
                end
                lfsr   = lfsr_step(lfsr);
                rdy[p] = lfsr[0];
            end
            rsp_ready_0 = rdy[0];
            rsp_ready_1 = rdy[1];
            req_valid_0 = sent[0] < burst_len;
            req_valid_1 = sent[1] < burst_len;
            req_0       = burst_req(0, sent[0]);
            req_1       = burst_req(1, sent[1]);
            #1;
            alw = {req_allowin_1, req_allowin_0};
            for (int p = 0; p < 2; p++) begin
                // open when nothing is owed or the held result leaves now
                check_flag($sformatf("req_allowin_%0d", p), alw[p],
                           (sent[p] == done[p]) || rdy[p]);
                if (vld[p] && rdy[p]) begin
                    done[p]++;
                end
                if (sent[p] < burst_len && alw[p]) begin
                    sent[p]++;
                end
            end
            @(negedge clk);
        end
        req_valid_0 = 1'b0;
        req_valid_1 = 1'b0;
        rsp_ready_0 = 1'b1;
        rsp_ready_1 = 1'b1;
        if (rsp_valid_0 || rsp_valid_1) begin
            report_error("a result appeared after the burst was drained");
        end
    endtask

    task automatic run_op(op_t o);
        case (o.kind)
            op_cfg: begin
                cfg = o.cfg;
                @(negedge clk);
            end
            op_wr: begin
                wr_en    = 1'b1;
                wr_index = tlb_idx_w'(o.index);
                wr_entry = o.ent;
                @(negedge clk);
                wr_en = 1'b0;
            end
            op_rd: begin
                rd_en    = 1'b1;
                rd_index = tlb_idx_w'(o.index);
                @(negedge clk);
                rd_en = 1'b0;
                if (!rd_valid) begin
                    report_error("rd_valid did not rise one cycle after rd_en");
                end
                check_entry("rd_entry", rd_entry, o.ent);
            end
            op_inv: begin
                inv_en = 1'b1;
                inv    = o.inv;
                @(negedge clk);
                inv_en = 1'b0;
            end
            op_xl:    do_translate(o.port, o.req, o.exp);
            op_burst: run_burst();
        endcase
    endtask

    initial begin
        rst_n       = 1'b0;
        cfg         = '0;
        // requests and reads stay raised while reset holds the outputs low
        req_valid_0 = 1'b1;
        req_0       = '0;
        rsp_ready_0 = 1'b1;
        req_valid_1 = 1'b1;
        req_1       = '0;
        rsp_ready_1 = 1'b1;
        wr_en       = 1'b0;
        wr_index    = '0;
        wr_entry    = '0;
        rd_en       = 1'b1;
        rd_index    = '0;
        inv_en      = 1'b0;
        inv         = '0;
        build_table();
        cycle_limit = 20 * n_ops;
        repeat (4) @(negedge clk);
        if ({rsp_valid_0, rsp_valid_1, rd_valid} !== 3'b000) begin
            report_error("a valid output was set during reset");
        end
        req_valid_0 = 1'b0;
        req_valid_1 = 1'b0;
        rd_en       = 1'b0;
        rst_n       = 1'b1;
        @(negedge clk);
        for (cur_op = 0; cur_op < n_ops; cur_op++) begin
            run_op(tbl[cur_op]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
hw/mmu_pkg.sv
hw/tlb_array.sv
hw/tlb_search.sv
hw/xlat_stage.sv
hw/mmu_top.sv
bench/mmu_tb.sv

//--- run.sh
#!/bin/sh
# builds the MMU testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module mmu_tb -Mdir obj_dir -o mmu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/mmu_sim > sim.log 2>&1
sim_status=$?

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
exit 0
